// ==== source/btc_dec_macros.svh ====
`ifndef BTC_DEC_MACROS_SVH
`define BTC_DEC_MACROS_SVH

// ----------------------------------------
// soft value widths of the lane
// ----------------------------------------

// channel LLR
`define BTC_LLR_W     4
// extrinsic value
`define BTC_EXTR_W    5
// unsigned scale, units of 1/8
`define BTC_ALPHA_W   4
// LLR + alpha * extrinsic, saturated
`define BTC_METRIC_W  7

// ----------------------------------------
// sizes
// ----------------------------------------

// default line length
`define BTC_DEC_NUM   8
// metric magnitude
`define BTC_MAG_W     6

`endif

// ==== source/btc_dec_pkg.sv ====
`include "btc_dec_macros.svh"

package btc_dec_pkg;

  // ----------------------------------------
  // frame strobes, travel with every sample
  // ----------------------------------------

  typedef struct packed {
    // start of frame
    logic sof;
    // start of codeword
    logic sop;
    // end of codeword
    logic eop;
    // end of frame
    logic eof;
    // shortened position, excluded from decoding
    logic mask;
  } strb_t;

  // ----------------------------------------
  // soft values
  // ----------------------------------------

  typedef logic signed [`BTC_LLR_W-1:0]    llr_t;
  typedef logic signed [`BTC_EXTR_W-1:0]   extr_t;
  typedef logic        [`BTC_ALPHA_W-1:0]  alpha_t;
  typedef logic signed [`BTC_METRIC_W-1:0] metric_t;
  typedef logic        [`BTC_MAG_W-1:0]    mag_t;

endpackage

// ==== source/btc_dec_comp_code_source.sv ====
`include "btc_dec_macros.svh"

// row mode serializes a whole line lsb first
// column mode registers a single indexed value
module btc_dec_comp_code_source #(
  parameter int pDEC_NUM = `BTC_DEC_NUM,
  parameter int pDEC_IDX = 0
) (
  input  logic                iclk,
  input  logic                ireset,
  input  logic                iclkena,
  input  logic                irow_mode,
  input  logic                ival,
  input  btc_dec_pkg::strb_t  istrb,
  input  btc_dec_pkg::llr_t   iLLR   [pDEC_NUM],
  input  btc_dec_pkg::extr_t  iLextr [pDEC_NUM],
  input  btc_dec_pkg::alpha_t ialpha,
  output logic                oval,
  output btc_dec_pkg::strb_t  ostrb,
  output btc_dec_pkg::llr_t   oLLR,
  output btc_dec_pkg::extr_t  oLextr,
  output btc_dec_pkg::alpha_t oalpha
);

  localparam int cW = $clog2(pDEC_NUM);

  // top bit is the busy and valid flag, low bits the sample index
  logic [cW:0]         val_cnt;
  // sample index of the current output
  logic [cW-1:0]       idx;
  // strobes of the line being serialized
  btc_dec_pkg::strb_t  strb;
  btc_dec_pkg::alpha_t alpha_r;

  btc_dec_pkg::llr_t   llr_line   [pDEC_NUM];
  btc_dec_pkg::extr_t  lextr_line [pDEC_NUM];

  // ----------------------------------------
  // valid generator
  // ----------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      val_cnt <= '0;
    end else if (iclkena) begin
      if (ival && irow_mode) begin
        // N pulses, index 0 first
        val_cnt <= (cW + 1)'(pDEC_NUM);
      end else if (ival) begin
        // all ones wraps to zero after one pulse
        val_cnt <= '1;
      end else begin
        val_cnt <= val_cnt + val_cnt[cW];
      end
    end
  end

  assign oval = val_cnt[cW];
  assign idx  = val_cnt[cW-1:0];

  // ----------------------------------------
  // strobe regeneration
  // ----------------------------------------

  always_ff @(posedge iclk) begin
    if (iclkena) begin
      if (ival) begin
        strb <= istrb;
      end
      if (irow_mode) begin
        // whole line becomes one serial packet
        ostrb.sof  <= istrb.sof & ival;
        ostrb.sop  <= istrb.sop & ival;
        // set on the sample after index N-2, the last one
        ostrb.eop  <= strb.eop & oval & (idx == cW'(pDEC_NUM - 2));
        ostrb.eof  <= strb.eof & oval & (idx == cW'(pDEC_NUM - 2));
        // first sample must see the new line's mask
        ostrb.mask <= ival ? istrb.mask : strb.mask;
      end else begin
        ostrb <= istrb;
      end
    end
  end

  // ----------------------------------------
  // line shift registers, lsb first
  // ----------------------------------------

  always_ff @(posedge iclk) begin
    if (iclkena) begin
      if (ival) begin
        alpha_r <= ialpha;
      end
      if (irow_mode) begin
        if (ival) begin
          llr_line   <= iLLR;
          lextr_line <= iLextr;
        end else begin
          for (int i = 0; i < pDEC_NUM - 1; i++) begin
            llr_line[i]   <= llr_line[i+1];
            lextr_line[i] <= lextr_line[i+1];
          end
        end
      end else if (ival) begin
        // column mode, only the selected position
        llr_line[0]   <= iLLR[pDEC_IDX];
        lextr_line[0] <= iLextr[pDEC_IDX];
      end
    end
  end

  assign oLLR   = llr_line[0];
  assign oLextr = lextr_line[0];
  assign oalpha = alpha_r;

  // ----------------------------------------
  // checks
  // ----------------------------------------

  // no new line while the previous one is still shifting out
  a_no_ival_busy : assert property (
    @(posedge iclk) disable iff (ireset)
    (iclkena && ival && irow_mode) |-> !val_cnt[cW]
  );

endmodule

// ==== source/btc_dec_metric_combiner.sv ====
`include "btc_dec_macros.svh"

// metric = sat(LLR + (alpha * Lextr) >>> 3)
module btc_dec_metric_combiner (
  input  logic                 iclk,
  input  logic                 ireset,
  input  logic                 iclkena,
  input  logic                 ival,
  input  btc_dec_pkg::strb_t   istrb,
  input  btc_dec_pkg::llr_t    iLLR,
  input  btc_dec_pkg::extr_t   iLextr,
  input  btc_dec_pkg::alpha_t  ialpha,
  output logic                 oval,
  output btc_dec_pkg::strb_t   ostrb,
  output btc_dec_pkg::metric_t ometric
);

  // product of signed extrinsic and zero extended alpha
  localparam int cPROD_W = `BTC_EXTR_W + `BTC_ALPHA_W + 1;
  localparam int cSUM_W  = cPROD_W + 1;
  // symmetric saturation bound
  localparam int cMAX    = 2**(`BTC_METRIC_W - 1) - 1;

  logic signed [cPROD_W-1:0] prod;
  logic signed [cPROD_W-1:0] scaled;
  logic signed [cSUM_W-1:0]  sum;
  btc_dec_pkg::metric_t      metric;

  // ----------------------------------------
  // scale, add, saturate
  // ----------------------------------------

  always_comb begin
    prod   = iLextr * $signed({1'b0, ialpha});
    // alpha is in 1/8 units, floor division
    scaled = prod >>> 3;
    sum    = scaled + iLLR;
    if (sum > cMAX) begin
      metric = btc_dec_pkg::metric_t'(cMAX);
    end else if (sum < -cMAX) begin
      metric = btc_dec_pkg::metric_t'(-cMAX);
    end else begin
      metric = btc_dec_pkg::metric_t'(sum);
    end
  end

  // ----------------------------------------
  // output stage
  // ----------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      oval <= 1'b0;
    end else if (iclkena) begin
      oval <= ival;
    end
  end

  // strobes delayed alongside the metric
  always_ff @(posedge iclk) begin
    if (iclkena) begin
      ostrb   <= istrb;
      ometric <= metric;
    end
  end

endmodule

// ==== source/btc_dec_spc_decoder.sv ====
`include "btc_dec_macros.svh"

// single parity check decoder front end
// per codeword: hard bits, syndrome, two minima and index of the first
module btc_dec_spc_decoder #(
  parameter int pDEC_NUM = `BTC_DEC_NUM
) (
  input  logic                          iclk,
  input  logic                          ireset,
  input  logic                          iclkena,
  input  logic                          ival,
  input  btc_dec_pkg::strb_t            istrb,
  input  btc_dec_pkg::metric_t          imetric,
  output logic                          oval,
  output logic                          osof,
  output logic                          oeof,
  output logic [pDEC_NUM-1:0]           ohard,
  output logic                          osyndrome,
  output btc_dec_pkg::mag_t             omin1,
  output btc_dec_pkg::mag_t             omin2,
  output logic [$clog2(pDEC_NUM)-1:0]   omin_idx
);

  localparam int cW       = $clog2(pDEC_NUM);
  localparam int cMAG_MAX = 2**`BTC_MAG_W - 1;

  // position counter, extra bit catches overlong codewords
  logic [cW:0]                 cnt;
  logic [cW:0]                 pos;
  logic                        in_pkt;

  // accumulators of the running codeword
  logic [pDEC_NUM-1:0]         hard_acc;
  logic                        par_acc;
  btc_dec_pkg::mag_t           min1_acc;
  btc_dec_pkg::mag_t           min2_acc;
  logic [cW-1:0]               idx_acc;
  logic                        sof_acc;

  // values after the current sample
  logic [pDEC_NUM-1:0]         hard_nxt;
  logic                        par_nxt;
  btc_dec_pkg::mag_t           min1_nxt;
  btc_dec_pkg::mag_t           min2_nxt;
  logic [cW-1:0]               idx_nxt;
  logic                        sof_nxt;

  logic                        neg;
  logic [`BTC_METRIC_W-1:0]    abs_val;
  btc_dec_pkg::mag_t           mag;

  // ----------------------------------------
  // sample update
  // ----------------------------------------

  always_comb begin
    neg     = imetric[`BTC_METRIC_W-1];
    abs_val = neg ? -imetric : imetric;
    // -64 has no 6 bit magnitude
    mag     = (abs_val > cMAG_MAX) ? '1 : btc_dec_pkg::mag_t'(abs_val);
    pos     = istrb.sop ? '0 : cnt;
    if (istrb.sop) begin
      // fresh codeword
      hard_nxt = '0;
      par_nxt  = 1'b0;
      min1_nxt = btc_dec_pkg::mag_t'(cMAG_MAX);
      min2_nxt = btc_dec_pkg::mag_t'(cMAG_MAX);
      idx_nxt  = '0;
      sof_nxt  = istrb.sof;
    end else begin
      hard_nxt = hard_acc;
      par_nxt  = par_acc;
      min1_nxt = min1_acc;
      min2_nxt = min2_acc;
      idx_nxt  = idx_acc;
      sof_nxt  = sof_acc | istrb.sof;
    end
    // shortened positions leave everything untouched
    if (!istrb.mask) begin
      hard_nxt[pos[cW-1:0]] = neg;
      par_nxt = par_nxt ^ neg;
      // strict compare, earlier position wins a tie
      if (mag < min1_nxt) begin
        min2_nxt = min1_nxt;
        min1_nxt = mag;
        idx_nxt  = pos[cW-1:0];
      end else if (mag < min2_nxt) begin
        min2_nxt = mag;
      end
    end
  end

  // ----------------------------------------
  // control
  // ----------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      cnt    <= '0;
      in_pkt <= 1'b0;
      oval   <= 1'b0;
    end else if (iclkena) begin
      oval <= ival & istrb.eop;
      if (ival) begin
        cnt    <= pos + 1'b1;
        in_pkt <= ~istrb.eop;
      end
    end
  end

  // ----------------------------------------
  // accumulators and result registers
  // ----------------------------------------

  always_ff @(posedge iclk) begin
    if (iclkena && ival) begin
      hard_acc <= hard_nxt;
      par_acc  <= par_nxt;
      min1_acc <= min1_nxt;
      min2_acc <= min2_nxt;
      idx_acc  <= idx_nxt;
      sof_acc  <= sof_nxt;
      // result of the closing sample
      if (istrb.eop) begin
        ohard     <= hard_nxt;
        osyndrome <= par_nxt;
        omin1     <= min1_nxt;
        omin2     <= min2_nxt;
        omin_idx  <= idx_nxt;
        osof      <= sof_nxt;
        oeof      <= istrb.eof;
      end
    end
  end

  // ----------------------------------------
  // checks
  // ----------------------------------------

  // a continuation sample needs an open codeword
  a_sop_first : assert property (
    @(posedge iclk) disable iff (ireset)
    (iclkena && ival && !istrb.sop) |-> in_pkt
  );

  // codeword never longer than the line
  a_pos_range : assert property (
    @(posedge iclk) disable iff (ireset)
    (iclkena && ival) |-> (pos < pDEC_NUM)
  );

endmodule

// ==== source/btc_dec_comp_unit.sv ====
`include "btc_dec_macros.svh"

// one component code lane: source, combiner, SPC decoder
module btc_dec_comp_unit #(
  parameter int pDEC_NUM = `BTC_DEC_NUM,
  parameter int pDEC_IDX = 0
) (
  input  logic                          iclk,
  input  logic                          ireset,
  input  logic                          iclkena,
  input  logic                          irow_mode,
  input  logic                          ival,
  input  btc_dec_pkg::strb_t            istrb,
  input  btc_dec_pkg::llr_t             iLLR   [pDEC_NUM],
  input  btc_dec_pkg::extr_t            iLextr [pDEC_NUM],
  input  btc_dec_pkg::alpha_t           ialpha,
  output logic                          oval,
  output logic                          osof,
  output logic                          oeof,
  output logic [pDEC_NUM-1:0]           ohard,
  output logic                          osyndrome,
  output btc_dec_pkg::mag_t             omin1,
  output btc_dec_pkg::mag_t             omin2,
  output logic [$clog2(pDEC_NUM)-1:0]   omin_idx
);

  // ----------------------------------------
  // source to combiner
  // ----------------------------------------

  logic                 src_val;
  btc_dec_pkg::strb_t   src_strb;
  btc_dec_pkg::llr_t    src_llr;
  btc_dec_pkg::extr_t   src_lextr;
  btc_dec_pkg::alpha_t  src_alpha;

  // combiner to decoder
  logic                 cmb_val;
  btc_dec_pkg::strb_t   cmb_strb;
  btc_dec_pkg::metric_t cmb_metric;

  btc_dec_comp_code_source #(
    .pDEC_NUM (pDEC_NUM),
    .pDEC_IDX (pDEC_IDX)
  ) u_source (
    .iclk      (iclk),
    .ireset    (ireset),
    .iclkena   (iclkena),
    .irow_mode (irow_mode),
    .ival      (ival),
    .istrb     (istrb),
    .iLLR      (iLLR),
    .iLextr    (iLextr),
    .ialpha    (ialpha),
    .oval      (src_val),
    .ostrb     (src_strb),
    .oLLR      (src_llr),
    .oLextr    (src_lextr),
    .oalpha    (src_alpha)
  );

  btc_dec_metric_combiner u_combiner (
    .iclk    (iclk),
    .ireset  (ireset),
    .iclkena (iclkena),
    .ival    (src_val),
    .istrb   (src_strb),
    .iLLR    (src_llr),
    .iLextr  (src_lextr),
    .ialpha  (src_alpha),
    .oval    (cmb_val),
    .ostrb   (cmb_strb),
    .ometric (cmb_metric)
  );

  btc_dec_spc_decoder #(
    .pDEC_NUM (pDEC_NUM)
  ) u_decoder (
    .iclk      (iclk),
    .ireset    (ireset),
    .iclkena   (iclkena),
    .ival      (cmb_val),
    .istrb     (cmb_strb),
    .imetric   (cmb_metric),
    .oval      (oval),
    .osof      (osof),
    .oeof      (oeof),
    .ohard     (ohard),
    .osyndrome (osyndrome),
    .omin1     (omin1),
    .omin2     (omin2),
    .omin_idx  (omin_idx)
  );

endmodule

// ==== tests/btc_dec_tb.sv ====
`include "btc_dec_macros.svh"

module btc_dec_tb;

  localparam int N         = `BTC_DEC_NUM;
  localparam int IDX       = 2;
  localparam int CW        = $clog2(N);
  localparam int MAG_MAX   = 2**`BTC_MAG_W - 1;
  localparam int MET_MAX   = 2**(`BTC_METRIC_W - 1) - 1;
  localparam int TIMEOUT   = 200;
  localparam int N_RESULTS = 200 + 60 + 60 + 40;

  // one expected SPC result, lat of 0 skips the latency check
  typedef struct {
    logic         sof;
    logic         eof;
    logic [N-1:0] hard;
    logic         syndrome;
    int           min1;
    int           min2;
    int           min_idx;
    int           t_ival;
    int           lat;
  } result_t;

  logic                iclk;
  logic                ireset;
  logic                iclkena;
  logic                irow_mode;
  logic                ival;
  btc_dec_pkg::strb_t  istrb;
  btc_dec_pkg::llr_t   iLLR   [N];
  btc_dec_pkg::extr_t  iLextr [N];
  btc_dec_pkg::alpha_t ialpha;
  logic                oval;
  logic                osof;
  logic                oeof;
  logic [N-1:0]        ohard;
  logic                osyndrome;
  btc_dec_pkg::mag_t   omin1;
  btc_dec_pkg::mag_t   omin2;
  logic [CW-1:0]       omin_idx;

  integer  seed = 66;
  int      cyc = 0;
  int      n_checked = 0;
  bit      stall_on = 0;
  result_t exp_q [$];

  // codeword being collected by the model
  int cw_metric [N];
  bit cw_mask   [N];
  int cw_len;

  btc_dec_comp_unit #(
    .pDEC_NUM (N),
    .pDEC_IDX (IDX)
  ) dut0 (
    .iclk      (iclk),
    .ireset    (ireset),
    .iclkena   (iclkena),
    .irow_mode (irow_mode),
    .ival      (ival),
    .istrb     (istrb),
    .iLLR      (iLLR),
    .iLextr    (iLextr),
    .ialpha    (ialpha),
    .oval      (oval),
    .osof      (osof),
    .oeof      (oeof),
    .ohard     (ohard),
    .osyndrome (osyndrome),
    .omin1     (omin1),
    .omin2     (omin2),
    .omin_idx  (omin_idx)
  );

  // ----------------------------------------
  // clock and cycle count
  // ----------------------------------------

  initial begin
    iclk = 1'b0;
    forever #10 iclk = ~iclk;
  end

  always @(posedge iclk) begin
    cyc <= cyc + 1;
  end

  // ----------------------------------------
  // helpers
  // ----------------------------------------

  task automatic abort_run();
    $display("Regression failed");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_val(input string name, input logic [63:0] got,
                           input logic [63:0] exp);
    if (got !== exp) begin
      $display("ERROR time %0t %s got %0h expected %0h", $time, name, got, exp);
      abort_run();
    end
  endtask

  function automatic int rand_range(input int lo, input int hi);
    return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
  endfunction

  // llr + floor(alpha * extr / 8), clipped to the symmetric metric range
  function automatic int combine(input int llr, input int extr, input int alpha);
    int sum;
    sum = ((extr * alpha) >>> 3) + llr;
    if (sum > MET_MAX) begin
      sum = MET_MAX;
    end else if (sum < -MET_MAX) begin
      sum = -MET_MAX;
    end
    return sum;
  endfunction

  // SPC reference over cw_metric / cw_mask, result queued for the monitor
  task automatic push_expected(input logic sof, input logic eof, input int lat);
    result_t r;
    int      p;
    int      mag;
    r.sof      = sof;
    r.eof      = eof;
    r.hard     = '0;
    r.syndrome = 1'b0;
    r.min1     = MAG_MAX;
    r.min2     = MAG_MAX;
    r.min_idx  = 0;
    r.t_ival   = cyc;
    r.lat      = lat;
    for (p = 0; p < cw_len; p++) begin
      // shortened positions do not count
      if (!cw_mask[p]) begin
        mag        = (cw_metric[p] < 0) ? -cw_metric[p] : cw_metric[p];
        r.hard[p]  = (cw_metric[p] < 0);
        r.syndrome = r.syndrome ^ r.hard[p];
        // ties keep the earlier position
        if (mag < r.min1) begin
          r.min2    = r.min1;
          r.min1    = mag;
          r.min_idx = p;
        end else if (mag < r.min2) begin
          r.min2 = mag;
        end
      end
    end
    exp_q.push_back(r);
  endtask

  // idle until n enabled cycles passed, stalls drawn at random
  task automatic idle_cycles(input int n);
    int done;
    int guard;
    done  = 0;
    guard = 0;
    ival  = 1'b0;
    while (done < n) begin
      if (guard >= TIMEOUT) begin
        $display("idle phase did not complete within timeout");
        abort_run();
      end else begin
        iclkena = stall_on ? (rand_range(0, 99) >= 30) : 1'b1;
        @(posedge iclk);
        #2;
        if (iclkena) begin
          done++;
        end
        guard++;
      end
    end
  endtask

  task automatic wait_results();
    int guard;
    guard = 0;
    while (exp_q.size() != 0) begin
      if (guard >= TIMEOUT) begin
        $display("no result within timeout");
        abort_run();
      end else begin
        idle_cycles(1);
        guard++;
      end
    end
  endtask

  // ----------------------------------------
  // stimulus
  // ----------------------------------------

  // one line on the inputs, the clock is enabled for the ival cycle
  task automatic drive_line(input logic row, input logic sof, input logic sop,
                            input logic eop, input logic eof, input logic mask,
                            input bit extreme);
    int i;
    iclkena    = 1'b1;
    ival       = 1'b1;
    irow_mode  = row;
    istrb.sof  = sof;
    istrb.sop  = sop;
    istrb.eop  = eop;
    istrb.eof  = eof;
    istrb.mask = mask;
    ialpha     = extreme ? 4'd15 : btc_dec_pkg::alpha_t'(rand_range(0, 15));
    for (i = 0; i < N; i++) begin
      if (extreme) begin
        // rails of both inputs
        iLLR[i]   = rand_range(0, 1) ? 4'sd7 : -4'sd8;
        iLextr[i] = rand_range(0, 1) ? 5'sd15 : -5'sd16;
      end else begin
        iLLR[i]   = btc_dec_pkg::llr_t'(rand_range(-8, 7));
        iLextr[i] = btc_dec_pkg::extr_t'(rand_range(-16, 15));
      end
    end
  endtask

  task automatic run_rows(input int n_lines);
    int   ln;
    int   i;
    logic sof;
    logic eof;
    logic mask;
    for (ln = 0; ln < n_lines; ln++) begin
      sof  = rand_range(0, 1);
      eof  = rand_range(0, 1);
      mask = (rand_range(0, 9) == 0);
      drive_line(1'b1, sof, 1'b1, 1'b1, eof, mask, rand_range(0, 7) == 0);
      // whole line forms one codeword
      cw_len = N;
      for (i = 0; i < N; i++) begin
        cw_metric[i] = combine(iLLR[i], iLextr[i], ialpha);
        cw_mask[i]   = mask;
      end
      push_expected(sof, eof, stall_on ? 0 : N + 2);
      @(posedge iclk);
      #2;
      // next line starts once the last sample is out
      idle_cycles(N + rand_range(0, 2));
    end
  endtask

  task automatic run_columns(input int n_cw);
    int   c;
    int   k;
    int   len;
    logic sof;
    logic eof;
    for (c = 0; c < n_cw; c++) begin
      len = rand_range(2, N);
      sof = rand_range(0, 1);
      eof = rand_range(0, 1);
      for (k = 0; k < len; k++) begin
        drive_line(1'b0, sof && (k == 0), k == 0, k == len - 1, eof && (k == len - 1),
                   rand_range(0, 9) == 0, rand_range(0, 9) == 0);
        // only the selected column enters the codeword
        cw_metric[k] = combine(iLLR[IDX], iLextr[IDX], ialpha);
        cw_mask[k]   = istrb.mask;
        if (k == len - 1) begin
          cw_len = len;
          push_expected(sof, eof, stall_on ? 0 : 3);
        end
        @(posedge iclk);
        #2;
        idle_cycles(rand_range(0, 1));
      end
    end
  endtask

  // ----------------------------------------
  // monitor, samples at the falling edge
  // ----------------------------------------

  always @(negedge iclk) begin
    result_t r;
    // a held oval during a stall is the same result
    if (!ireset && oval && iclkena) begin
      if (exp_q.size() == 0) begin
        $display("result arrived with no codeword outstanding");
        abort_run();
      end else begin
        r = exp_q.pop_front();
        check_val("osof", osof, r.sof);
        check_val("oeof", oeof, r.eof);
        check_val("ohard", ohard, r.hard);
        check_val("osyndrome", osyndrome, r.syndrome);
        check_val("omin1", omin1, r.min1);
        check_val("omin2", omin2, r.min2);
        check_val("omin_idx", omin_idx, r.min_idx);
        if (r.lat != 0) begin
          check_val("latency", cyc - r.t_ival, r.lat);
        end
        n_checked++;
      end
    end
  end

  // ----------------------------------------
  // main sequence
  // ----------------------------------------

  initial begin
    int i;
    ireset    = 1'b1;
    iclkena   = 1'b1;
    irow_mode = 1'b1;
    ival      = 1'b0;
    istrb     = '0;
    ialpha    = '0;
    for (i = 0; i < N; i++) begin
      iLLR[i]   = '0;
      iLextr[i] = '0;
    end
    repeat (4) @(posedge iclk);
    #2;
    ireset = 1'b0;

    // quiet after reset
    for (i = 0; i < 20; i++) begin
      @(negedge iclk);
      check_val("oval", oval, 1'b0);
    end
    @(posedge iclk);
    #2;

    run_rows(200);
    wait_results();
    run_columns(60);
    wait_results();

    // same traffic with a gated clock
    stall_on = 1'b1;
    run_rows(60);
    wait_results();
    run_columns(40);
    wait_results();

    if (n_checked == N_RESULTS) begin
      $display("Regression passed");
      $finish;
    end else begin
      $display("only %0d of %0d results were checked", n_checked, N_RESULTS);
      abort_run();
    end
  end

endmodule

// ==== sim.f ====
+incdir+source
source/btc_dec_pkg.sv
source/btc_dec_comp_code_source.sv
source/btc_dec_metric_combiner.sv
source/btc_dec_spc_decoder.sv
source/btc_dec_comp_unit.sv
tests/btc_dec_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the BTC component lane testbench with Verilator

cd "$(dirname "$0")"
status=$?
if [ $status -ne 0 ]; then
  echo "cannot enter the project directory"
  exit 1
fi

BUILD_DIR=obj_dir
LOG=sim.log
TOP=btc_dec_tb

verilator --binary --assert -Wno-fatal \
  --top-module "$TOP" \
  -Mdir "$BUILD_DIR" \
  -o "$TOP" \
  -f sim.f
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

"./$BUILD_DIR/$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
fi

grep -qx "Regression passed" "$LOG"
status=$?
if [ $status -eq 0 ]; then
  echo "PASS"
  exit 0
else
  echo "FAIL, see $LOG"
  exit 1
fi
